//--- include/mesh_defs.svh
// Mesh fabric defines for node count, message width and payload width

`ifndef MESH_DEFS_SVH
`define MESH_DEFS_SVH

// ==========================================================
// Fabric size
// ==========================================================

// Nodes in the single row, one column index each
// Column field is 4 bits, so at most 16 nodes
`define MESH_NODES 4

// ==========================================================
// Message layout
// ==========================================================

// Whole message carried on every stream
`define MESH_MSG_W 32

// Payload field, also the width of each node output register
`define MESH_PAYLOAD_W 16

`endif

//--- source/mesh_pkg.sv
// Mesh package with message field types, opcode constants and queue states

`include "mesh_defs.svh"

package mesh_pkg;

    // Message fields: opcode [31:30], column [29:26], reserved [25:16], payload [15:0]
    typedef logic [`MESH_MSG_W-1:0]     message_t;
    typedef logic [1:0]                 opcode_t;
    typedef logic [3:0]                 column_t;
    typedef logic [`MESH_PAYLOAD_W-1:0] payload_t;

    // Recognised opcodes, 0 and 3 are invalid
    localparam opcode_t OP_LOAD    = 2'd1;
    localparam opcode_t OP_FORWARD = 2'd2;

    // Occupancy of a two-entry queue
    typedef enum logic [1:0] {
        EMPTY,
        ONE,
        FULL
    } queue_state_t;

    // Field extraction
    function automatic opcode_t msg_opcode(message_t msg);
        return msg[31:30];
    endfunction

    function automatic column_t msg_column(message_t msg);
        return msg[29:26];
    endfunction

    function automatic payload_t msg_payload(message_t msg);
        return msg[`MESH_PAYLOAD_W-1:0];
    endfunction

endpackage : mesh_pkg

//--- source/mesh_ingress.sv
// Mesh ingress with a two-entry inbound queue that drops messages with unknown opcodes

module mesh_ingress (
    input  logic               i_clk,
    input  logic               i_reset,
    // Inbound stream
    input  mesh_pkg::message_t i_inbound_data,
    input  logic               i_inbound_valid,
    output logic               o_inbound_ready,
    // Stream towards node 0
    output mesh_pkg::message_t o_data,
    output logic               o_valid,
    input  logic               i_ready,
    // Nothing held
    output logic               o_idle
);

    // ==========================================================
    // Queue storage and control
    // ==========================================================

    mesh_pkg::queue_state_t q_state;
    mesh_pkg::message_t     slot_head;
    mesh_pkg::message_t     slot_tail;
    mesh_pkg::opcode_t      in_opcode;
    logic                   opcode_ok;
    logic                   wr_en;
    logic                   rd_en;

    // Opcode filter
    assign in_opcode = mesh_pkg::msg_opcode(i_inbound_data);
    assign opcode_ok = (in_opcode == mesh_pkg::OP_LOAD) ||
                       (in_opcode == mesh_pkg::OP_FORWARD);

    // Ready only from own occupancy
    assign o_inbound_ready = (q_state != mesh_pkg::FULL);

    // Bad opcodes are accepted but never written
    assign wr_en = i_inbound_valid && o_inbound_ready && opcode_ok;
    assign rd_en = o_valid && i_ready;

    // Head slot drives node 0
    assign o_valid = (q_state != mesh_pkg::EMPTY);
    assign o_data  = slot_head;
    assign o_idle  = (q_state == mesh_pkg::EMPTY);

    // ==========================================================
    // Occupancy FSM
    // ==========================================================

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            q_state <= mesh_pkg::EMPTY;
        end else begin
            case (q_state)
                mesh_pkg::EMPTY: begin
                    if (wr_en) q_state <= mesh_pkg::ONE;
                end
                mesh_pkg::ONE: begin
                    // Write and read together keep one entry
                    if (wr_en && !rd_en) q_state <= mesh_pkg::FULL;
                    else if (!wr_en && rd_en) q_state <= mesh_pkg::EMPTY;
                end
                mesh_pkg::FULL: begin
                    if (rd_en) q_state <= mesh_pkg::ONE;
                end
                default: q_state <= mesh_pkg::EMPTY;
            endcase
        end
    end

    // Slot updates keep the oldest message in the head
    always_ff @(posedge i_clk) begin
        case (q_state)
            mesh_pkg::EMPTY: begin
                if (wr_en) slot_head <= i_inbound_data;
            end
            mesh_pkg::ONE: begin
                // Head leaves and the new message takes its place
                if (wr_en && rd_en) slot_head <= i_inbound_data;
                else if (wr_en) slot_tail <= i_inbound_data;
            end
            mesh_pkg::FULL: begin
                // Tail moves up
                if (rd_en) slot_head <= slot_tail;
            end
            default: slot_head <= slot_head;
        endcase
    end

    // ==========================================================
    // Checks
    // ==========================================================

    // Full queue that is not read keeps both slots and its state
    a_no_overflow: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (q_state == mesh_pkg::FULL && !rd_en) |=>
            (q_state == mesh_pkg::FULL && $stable(slot_head) && $stable(slot_tail))
    );

endmodule : mesh_ingress

//--- source/mesh_node.sv
// Mesh node, single-entry routing stage that absorbs LOADs for its own column

module mesh_node #(
    parameter int COLUMN = 0
) (
    input  logic               i_clk,
    input  logic               i_reset,
    // Stream from the west
    input  mesh_pkg::message_t i_data,
    input  logic               i_valid,
    output logic               o_ready,
    // Stream to the east
    output mesh_pkg::message_t o_data,
    output logic               o_valid,
    input  logic               i_ready,
    // Node output register
    output mesh_pkg::payload_t o_output,
    // Nothing held
    output logic               o_idle
);

    // ==========================================================
    // Internal state
    // ==========================================================

    localparam mesh_pkg::column_t MY_COLUMN = mesh_pkg::column_t'(COLUMN);

    logic               held_valid;
    mesh_pkg::message_t held_data;
    mesh_pkg::payload_t output_q;
    logic               accept;
    logic               consume;
    logic               pass_on;
    logic               send;

    // Free now, or freed by the transfer east in this cycle
    assign o_ready = !held_valid || i_ready;

    assign accept = i_valid && o_ready;
    assign send   = held_valid && i_ready;

    // LOAD for this column stops here
    assign consume = accept &&
                     (mesh_pkg::msg_opcode(i_data) == mesh_pkg::OP_LOAD) &&
                     (mesh_pkg::msg_column(i_data) == MY_COLUMN);

    // Everything else goes east
    assign pass_on = accept && !consume;

    // ==========================================================
    // Pass-through register
    // ==========================================================

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            held_valid <= 1'b0;
        end else if (pass_on) begin
            held_valid <= 1'b1;
        end else if (send) begin
            held_valid <= 1'b0;
        end
    end

    // Payload capture
    always_ff @(posedge i_clk) begin
        if (pass_on) held_data <= i_data;
    end

    // ==========================================================
    // Output register
    // ==========================================================

    // Written on the acceptance edge, zero after reset
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            output_q <= '0;
        end else if (consume) begin
            output_q <= mesh_pkg::msg_payload(i_data);
        end
    end

    assign o_data   = held_data;
    assign o_valid  = held_valid;
    assign o_output = output_q;
    assign o_idle   = !held_valid;

    // ==========================================================
    // Checks
    // ==========================================================

    // Held message stays put until the next node takes it
    a_hold_stable: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_data))
    );

endmodule : mesh_node

//--- source/mesh_egress.sv
// Mesh egress, two-entry outbound queue for FORWARD messages plus the fabric idle flag

`include "mesh_defs.svh"

module mesh_egress (
    input  logic                   i_clk,
    input  logic                   i_reset,
    // Stream from the last node
    input  mesh_pkg::message_t     i_data,
    input  logic                   i_valid,
    output logic                   o_ready,
    // Idle levels from the rest of the fabric
    input  logic [`MESH_NODES-1:0] i_nodes_idle,
    input  logic                   i_ingress_idle,
    // Outbound stream
    output mesh_pkg::message_t     o_outbound_data,
    output logic                   o_outbound_valid,
    input  logic                   i_outbound_ready,
    // Whole fabric quiet
    output logic                   o_idle
);

    // ==========================================================
    // Queue storage and control
    // ==========================================================

    mesh_pkg::queue_state_t q_state;
    mesh_pkg::message_t     slot_head;
    mesh_pkg::message_t     slot_tail;
    logic                   is_forward;
    logic                   wr_en;
    logic                   rd_en;
    logic                   idle_q;
    logic                   idle_next;

    // Stray LOADs are accepted and dropped
    assign is_forward = (mesh_pkg::msg_opcode(i_data) == mesh_pkg::OP_FORWARD);

    assign o_ready = (q_state != mesh_pkg::FULL);
    assign wr_en   = i_valid && o_ready && is_forward;
    assign rd_en   = o_outbound_valid && i_outbound_ready;

    assign o_outbound_valid = (q_state != mesh_pkg::EMPTY);
    assign o_outbound_data  = slot_head;

    // ==========================================================
    // Occupancy FSM
    // ==========================================================

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            q_state <= mesh_pkg::EMPTY;
        end else begin
            case (q_state)
                mesh_pkg::EMPTY: begin
                    if (wr_en) q_state <= mesh_pkg::ONE;
                end
                mesh_pkg::ONE: begin
                    if (wr_en && !rd_en) q_state <= mesh_pkg::FULL;
                    else if (!wr_en && rd_en) q_state <= mesh_pkg::EMPTY;
                end
                mesh_pkg::FULL: begin
                    if (rd_en) q_state <= mesh_pkg::ONE;
                end
                default: q_state <= mesh_pkg::EMPTY;
            endcase
        end
    end

    // Head holds the oldest message
    always_ff @(posedge i_clk) begin
        case (q_state)
            mesh_pkg::EMPTY: begin
                if (wr_en) slot_head <= i_data;
            end
            mesh_pkg::ONE: begin
                if (wr_en && rd_en) slot_head <= i_data;
                else if (wr_en) slot_tail <= i_data;
            end
            mesh_pkg::FULL: begin
                if (rd_en) slot_head <= slot_tail;
            end
            default: slot_head <= slot_head;
        endcase
    end

    // ==========================================================
    // Idle flag
    // ==========================================================

    // Queue empty, nothing arriving, every stage upstream empty
    assign idle_next = (q_state == mesh_pkg::EMPTY) && !i_valid &&
                       (&i_nodes_idle) && i_ingress_idle;

    // Comes out of reset high
    always_ff @(posedge i_clk) begin
        if (i_reset) idle_q <= 1'b1;
        else idle_q <= idle_next;
    end

    assign o_idle = idle_q;

    // ==========================================================
    // Checks
    // ==========================================================

    // Outbound message held steady while the sink stalls
    a_outbound_stable: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (o_outbound_valid && !i_outbound_ready) |=>
            (o_outbound_valid && $stable(o_outbound_data))
    );

endmodule : mesh_egress

//--- source/mesh_top.sv
// Mesh top level, ingress queue feeding a row of routing nodes drained by the egress

`include "mesh_defs.svh"

module mesh_top (
    input  logic                                   i_clk,
    input  logic                                   i_reset,
    // Inbound stream
    input  mesh_pkg::message_t                     i_inbound_data,
    input  logic                                   i_inbound_valid,
    output logic                                   o_inbound_ready,
    // Outbound stream
    output mesh_pkg::message_t                     o_outbound_data,
    output logic                                   o_outbound_valid,
    input  logic                                   i_outbound_ready,
    // Node output registers, node k at bits k*16 upward
    output logic [`MESH_NODES*`MESH_PAYLOAD_W-1:0] o_outputs,
    // Whole fabric quiet
    output logic                                   o_idle
);

    // ==========================================================
    // Chain wiring
    // ==========================================================

    // Link k feeds node k, link MESH_NODES feeds the egress
    mesh_pkg::message_t     chain_data  [`MESH_NODES+1];
    logic                   chain_valid [`MESH_NODES+1];
    logic                   chain_ready [`MESH_NODES+1];
    logic [`MESH_NODES-1:0] nodes_idle;
    logic                   ingress_idle;

    // ==========================================================
    // Ingress
    // ==========================================================

    mesh_ingress u_ingress (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_inbound_data  (i_inbound_data),
        .i_inbound_valid (i_inbound_valid),
        .o_inbound_ready (o_inbound_ready),
        .o_data          (chain_data[0]),
        .o_valid         (chain_valid[0]),
        .i_ready         (chain_ready[0]),
        .o_idle          (ingress_idle)
    );

    // ==========================================================
    // Node row
    // ==========================================================

    for (genvar idx = 0; idx < `MESH_NODES; idx++) begin : gen_nodes
        mesh_node #(
            .COLUMN (idx)
        ) u_node (
            .i_clk    (i_clk),
            .i_reset  (i_reset),
            .i_data   (chain_data[idx]),
            .i_valid  (chain_valid[idx]),
            .o_ready  (chain_ready[idx]),
            .o_data   (chain_data[idx+1]),
            .o_valid  (chain_valid[idx+1]),
            .i_ready  (chain_ready[idx+1]),
            .o_output (o_outputs[idx*`MESH_PAYLOAD_W +: `MESH_PAYLOAD_W]),
            .o_idle   (nodes_idle[idx])
        );
    end

    // ==========================================================
    // Egress
    // ==========================================================

    mesh_egress u_egress (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_data           (chain_data[`MESH_NODES]),
        .i_valid          (chain_valid[`MESH_NODES]),
        .o_ready          (chain_ready[`MESH_NODES]),
        .i_nodes_idle     (nodes_idle),
        .i_ingress_idle   (ingress_idle),
        .o_outbound_data  (o_outbound_data),
        .o_outbound_valid (o_outbound_valid),
        .i_outbound_ready (i_outbound_ready),
        .o_idle           (o_idle)
    );

endmodule : mesh_top

//--- dv/tb_clock.sv
// Testbench clock and reset source, 100 unit period with reset held for 8 cycles

module tb_clock #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_reset
);

    // Free-running clock, first rising edge at one half period
    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_reset = 1'b0;
    end

endmodule : tb_clock

//--- dv/tb_mesh.sv
// Mesh fabric testbench, golden-file stimulus with random outbound back-pressure

`include "mesh_defs.svh"

module tb_mesh;

    // ==========================================================
    // Stimulus, golden data and DUT hookup
    // ==========================================================

    localparam int SEED    = 93198;
    localparam int MAX_MSG = 64;

    logic clk;
    logic rst;

    // DUT inputs, all known from time zero
    mesh_pkg::message_t inbound_data   = '0;
    logic               inbound_valid  = 1'b0;
    logic               outbound_ready = 1'b0;

    logic                                   inbound_ready;
    mesh_pkg::message_t                     outbound_data;
    logic                                   outbound_valid;
    logic [`MESH_NODES*`MESH_PAYLOAD_W-1:0] outputs;
    logic                                   idle;

    // Raw file image, then split into three tables
    logic [31:0]        golden_mem [0:255];
    mesh_pkg::message_t in_msgs    [0:MAX_MSG-1];
    mesh_pkg::message_t exp_out    [0:MAX_MSG-1];
    mesh_pkg::payload_t exp_final  [0:`MESH_NODES-1];
    int                 num_inputs;
    int                 num_expected;

    int out_count     = 0;
    int cycle_count   = 0;
    int timeout_limit = 1000;

    tb_clock u_clock (
        .o_clk   (clk),
        .o_reset (rst)
    );

    mesh_top DUT (
        .i_clk            (clk),
        .i_reset          (rst),
        .i_inbound_data   (inbound_data),
        .i_inbound_valid  (inbound_valid),
        .o_inbound_ready  (inbound_ready),
        .o_outbound_data  (outbound_data),
        .o_outbound_valid (outbound_valid),
        .i_outbound_ready (outbound_ready),
        .o_outputs        (outputs),
        .o_idle           (idle)
    );

    // ==========================================================
    // Helpers
    // ==========================================================

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            stop_run();
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_message(input mesh_pkg::message_t msg);
        logic taken;
        inbound_data  = msg;
        inbound_valid = 1'b1;
        taken         = 1'b0;
        while (!taken) begin
            // Ready is stable until the next rising edge
            taken = inbound_ready;
            @(negedge clk);
        end
    endtask

    // ==========================================================
    // Outbound sink and checker
    // ==========================================================

    always @(negedge clk) begin
        if (rst) begin
            outbound_ready = 1'b0;
        end else begin
            // Ready low about one cycle in three
            outbound_ready = ($urandom % 3) != 0;
            if (outbound_valid && outbound_ready) begin
                if (out_count >= num_expected) begin
                    $display("Outbound stream carried more messages than expected");
                    stop_run();
                end else begin
                    check_value("o_outbound_data", 64'(outbound_data),
                                64'(exp_out[out_count]));
                    out_count++;
                end
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Timeout, fabric did not finish within %0d cycles", timeout_limit);
            stop_run();
        end
    end

    // ==========================================================
    // Main sequence
    // ==========================================================

    initial begin
        string slice_name;
        void'($urandom(SEED));
        $readmemh("dv/mesh_golden.txt", golden_mem);
        num_inputs   = int'(golden_mem[0]);
        num_expected = int'(golden_mem[64]);
        if (num_inputs < 1 || num_inputs >= MAX_MSG || num_expected >= MAX_MSG) begin
            $display("Golden file is missing or has bad message counts");
            stop_run();
        end
        for (int i = 0; i < MAX_MSG - 1; i++) begin
            in_msgs[i] = golden_mem[1 + i];
            exp_out[i] = golden_mem[65 + i];
        end
        for (int k = 0; k < `MESH_NODES; k++) begin
            exp_final[k] = mesh_pkg::payload_t'(golden_mem[128 + k]);
        end
        timeout_limit = 40 * num_inputs + 100;

        // Wait out reset
        do @(negedge clk); while (rst !== 1'b0);

        // Values straight after reset
        check_value("o_idle", 64'(idle), 64'd1);
        check_value("o_outbound_valid", 64'(outbound_valid), 64'd0);
        check_value("o_inbound_ready", 64'(inbound_ready), 64'd1);
        for (int k = 0; k < `MESH_NODES; k++) begin
            slice_name = $sformatf("o_outputs[%0d]", k);
            check_value(slice_name, 64'(outputs[k*`MESH_PAYLOAD_W +: `MESH_PAYLOAD_W]), 64'd0);
        end

        // Inbound messages with random gaps
        for (int i = 0; i < num_inputs; i++) begin
            if (($urandom % 4) == 0) begin
                inbound_valid = 1'b0;
                @(negedge clk);
            end
            send_message(in_msgs[i]);
        end
        inbound_valid = 1'b0;

        // Idle flag lags one edge behind the ingress
        repeat (2) @(negedge clk);
        while (!idle) @(negedge clk);

        check_value("outbound count", 64'(out_count), 64'(num_expected));
        for (int k = 0; k < `MESH_NODES; k++) begin
            slice_name = $sformatf("o_outputs[%0d]", k);
            check_value(slice_name, 64'(outputs[k*`MESH_PAYLOAD_W +: `MESH_PAYLOAD_W]),
                        64'(exp_final[k]));
        end

        $display("All checks passed");
        $finish;
    end

endmodule : tb_mesh

//--- dv/mesh_golden.txt
// Mesh golden data, 32-bit hex words, up to four per line
// @00 input count then inputs, @40 outbound count then messages, @80 final output per node
@00
10
// LOADs, FORWARDs, bad opcodes and LOADs to columns 4 and 5
40001111 80000001 44002222 00005555
80AB0002 48003333 C0006666 50007777
8C120003 4C004444 4000AAAA 80000004
54008888 83FF0005 4800BBBB BC000006
@40
6
// FORWARDs in input order, unchanged
80000001 80AB0002 8C120003 80000004
83FF0005 BC000006
@80
// Node 0 up to node 3
0000AAAA 00002222 0000BBBB 00004444

//--- sim.f
+incdir+include
source/mesh_pkg.sv
source/mesh_ingress.sv
source/mesh_node.sv
source/mesh_egress.sv
source/mesh_top.sv
dv/tb_clock.sv
dv/tb_mesh.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the mesh testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mesh -f sim.f -o tb_mesh_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_mesh_sim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All checks passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
